//--- frontend_ibuf.f
src/frontend_pkg.sv
src/predecode_ibuf_if.sv
src/inst_buffer_bank.sv
src/fetch_packer.sv
src/inst_buffer.sv
src/frontend_ibuf.sv
tb/frontend_ibuf_checker.sv
tb/frontend_ibuf_tb.sv

//--- Bender.yml
package:
  name: frontend_ibuf

sources:
  - files:
      - src/frontend_pkg.sv
      - src/predecode_ibuf_if.sv
      - src/inst_buffer_bank.sv
      - src/fetch_packer.sv
      - src/inst_buffer.sv
      - src/frontend_ibuf.sv
  - target: test
    files:
      - tb/frontend_ibuf_checker.sv
      - tb/frontend_ibuf_tb.sv

//--- tb/frontend_ibuf_tb.sv
`timescale 1ns/1ps

module frontend_ibuf_tb;

    localparam int num_tests = 6;
    localparam int drain_limit = 100;

    logic clk;
    logic rst;
    logic fetch_valid;
    logic [frontend_pkg::offset_w-1:0] fetch_offset;
    logic [frontend_pkg::fetch_width-1:0][31:0] fetch_inst;
    logic [frontend_pkg::fsq_idx_w-1:0] fetch_fsq_idx;
    logic stall;
    logic redirect;
    logic fetch_ready;
    logic [frontend_pkg::fetch_width-1:0] out_en;
    logic [frontend_pkg::fetch_width-1:0][31:0] out_inst;
    logic [frontend_pkg::fetch_width-1:0][frontend_pkg::fsq_idx_w-1:0] out_fsq_idx;
    logic [frontend_pkg::fetch_width-1:0][frontend_pkg::offset_w-1:0] out_offset;
    logic [frontend_pkg::fetch_width-1:0] out_is_cf;
    logic full;

    int err_count;
    int in_count;
    int out_count;
    int model_size;
    int full_cycles;

    // Offset modes: 0 fixed, 1 cycles 1..3, 2 random, 3 sweeps 0..3.
    // Stall modes: 0 never, 1 first 40 cycles, 2 random.
    string test_name [num_tests];
    int blocks [num_tests];
    int off_mode [num_tests];
    int stall_mode [num_tests];
    int redir_cycle [num_tests];
    int exp_lanes [num_tests];
    bit exp_full [num_tests];
    bit table_ready;

    int tb_errors;
    int tests_failed;
    logic [frontend_pkg::offset_w-1:0] next_off;
    logic [frontend_pkg::fetch_width-1:0][31:0] next_inst;

    frontend_ibuf frontend_ibuf_inst (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_offset(fetch_offset),
        .fetch_inst(fetch_inst), .fetch_fsq_idx(fetch_fsq_idx), .stall(stall),
        .redirect(redirect), .fetch_ready(fetch_ready), .out_en(out_en),
        .out_inst(out_inst), .out_fsq_idx(out_fsq_idx), .out_offset(out_offset),
        .out_is_cf(out_is_cf), .full(full)
    );

    frontend_ibuf_checker checker_inst (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_offset(fetch_offset),
        .fetch_inst(fetch_inst), .fetch_fsq_idx(fetch_fsq_idx), .stall(stall),
        .redirect(redirect), .fetch_ready(fetch_ready), .out_en(out_en),
        .out_inst(out_inst), .out_fsq_idx(out_fsq_idx), .out_offset(out_offset),
        .out_is_cf(out_is_cf), .full(full), .err_count(err_count), .in_count(in_count),
        .out_count(out_count), .model_size(model_size), .full_cycles(full_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic set_test(input int t, input string name, input int nblk, input int om,
                            input int sm, input int rc, input int el, input bit ef);
        test_name[t] = name;
        blocks[t] = nblk;
        off_mode[t] = om;
        stall_mode[t] = sm;
        redir_cycle[t] = rc;
        exp_lanes[t] = el;
        exp_full[t] = ef;
    endtask

    task automatic make_block(input int t, input int blk);
        int kind;
        case (off_mode[t])
            1: next_off = frontend_pkg::offset_w'(1 + blk % 3);
            2: next_off = frontend_pkg::offset_w'($urandom % 4);
            3: next_off = frontend_pkg::offset_w'(blk % 4);
            default: next_off = '0;
        endcase
        for (int s = 0; s < frontend_pkg::fetch_width; s++) begin
            kind = $urandom % 4;
            next_inst[s] = $urandom;
            case (kind)
                0: next_inst[s][6:0] = frontend_pkg::opcode_branch;
                1: next_inst[s][6:0] = frontend_pkg::opcode_jal;
                2: next_inst[s][6:0] = frontend_pkg::opcode_jalr;
                default: next_inst[s][6:0] = 7'b0110011;
            endcase
        end
    endtask

    function automatic logic stall_for(input int t, input int cyc);
        case (stall_mode[t])
            1: return cyc < 40;
            2: return ($urandom % 3) == 0;
            default: return 1'b0;
        endcase
    endfunction

    initial begin
        int unsigned seed;
        int cyc;
        int blk;
        int wait_cnt;
        int err_start;
        int in_start;
        int out_start;
        int full_start;
        int test_err;
        seed = 48081;
        void'($urandom(seed));
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_offset = '0;
        fetch_inst = '0;
        fetch_fsq_idx = '0;
        stall = 1'b0;
        redirect = 1'b0;
        tb_errors = 0;
        tests_failed = 0;
        set_test(0, "stream_offset0", 12, 0, 0, -1, 48, 1'b0);
        set_test(1, "compact_offsets", 12, 1, 0, -1, 24, 1'b0);
        set_test(2, "offset_sweep", 16, 3, 0, -1, 40, 1'b0);
        set_test(3, "long_stall_fill", 12, 0, 1, -1, 48, 1'b1);
        set_test(4, "redirect_mid", 16, 0, 2, 10, -1, 1'b0);
        set_test(5, "random_wrap", 40, 2, 2, -1, -1, 1'b0);
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            err_start = err_count + tb_errors;
            in_start = in_count;
            out_start = out_count;
            full_start = full_cycles;
            blk = 0;
            cyc = 0;
            make_block(t, 0);
            while (blk < blocks[t]) begin
                @(posedge clk);
                fetch_valid <= 1'b1;
                fetch_offset <= next_off;
                fetch_inst <= next_inst;
                fetch_fsq_idx <= frontend_pkg::fsq_idx_w'(blk);
                stall <= stall_for(t, cyc);
                redirect <= (cyc == redir_cycle[t]);
                @(negedge clk);
                // A block offered under redirect is dropped and offered again.
                if (fetch_ready && !redirect) begin
                    blk++;
                    if (blk < blocks[t]) begin
                        make_block(t, blk);
                    end
                end
                cyc++;
            end
            @(posedge clk);
            fetch_valid <= 1'b0;
            stall <= 1'b0;
            redirect <= 1'b0;
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
            end while (model_size != 0 && wait_cnt < drain_limit);
            // One more cycle so the empty outputs are compared too.
            @(posedge clk);
            if (model_size != 0) begin
                $display("Test %s: buffer did not drain within %0d cycles",
                         test_name[t], drain_limit);
                tb_errors++;
            end
            if (exp_lanes[t] >= 0 && out_count - out_start != exp_lanes[t]) begin
                $display("MISMATCH lanes_out in %s: got 0x%0h expected 0x%0h",
                         test_name[t], out_count - out_start, exp_lanes[t]);
                tb_errors++;
            end
            if (exp_full[t] && full_cycles == full_start) begin
                $display("Test %s: full never rose while decode was stalled", test_name[t]);
                tb_errors++;
            end
            test_err = err_count + tb_errors - err_start;
            if (test_err != 0) begin
                tests_failed++;
            end
            $display("Test %0d %s: lanes in %0d, lanes out %0d, errors %0d, %s", t,
                     test_name[t], in_count - in_start, out_count - out_start, test_err,
                     (test_err == 0) ? "ok" : "FAILED");
        end
        $display("Summary: %0d tests, %0d failed, %0d checker errors, %0d testbench errors",
                 num_tests, tests_failed, err_count, tb_errors);
        if (tests_failed == 0 && err_count == 0 && tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Budget of eight cycles per block plus a margin per test.
    initial begin
        int total;
        total = 0;
        wait (table_ready);
        for (int t = 0; t < num_tests; t++) begin
            total += blocks[t];
        end
        #((total * 8 + 100 * num_tests) * 20);
        $display("Watchdog timeout: run went past %0d cycles", total * 8 + 100 * num_tests);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- tb/frontend_ibuf_checker.sv
`timescale 1ns/1ps

module frontend_ibuf_checker (
    input  logic clk,
    input  logic rst,
    input  logic fetch_valid,
    input  logic [frontend_pkg::offset_w-1:0] fetch_offset,
    input  logic [frontend_pkg::fetch_width-1:0][31:0] fetch_inst,
    input  logic [frontend_pkg::fsq_idx_w-1:0] fetch_fsq_idx,
    input  logic stall,
    input  logic redirect,
    input  logic fetch_ready,
    input  logic [frontend_pkg::fetch_width-1:0] out_en,
    input  logic [frontend_pkg::fetch_width-1:0][31:0] out_inst,
    input  logic [frontend_pkg::fetch_width-1:0][frontend_pkg::fsq_idx_w-1:0] out_fsq_idx,
    input  logic [frontend_pkg::fetch_width-1:0][frontend_pkg::offset_w-1:0] out_offset,
    input  logic [frontend_pkg::fetch_width-1:0] out_is_cf,
    input  logic full,
    output int err_count,
    output int in_count,
    output int out_count,
    output int model_size,
    output int full_cycles
);

    // Model of the buffer contents, front is the oldest instruction.
    logic [31:0] q_inst [$];
    logic [frontend_pkg::fsq_idx_w-1:0] q_fsq [$];
    logic [frontend_pkg::offset_w-1:0] q_off [$];

    // Block accepted at the last edge, still in the packer.
    logic pend_valid;
    logic [frontend_pkg::offset_w-1:0] pend_off;
    logic [frontend_pkg::fetch_width-1:0][31:0] pend_inst;
    logic [frontend_pkg::fsq_idx_w-1:0] pend_fsq;

    function automatic logic is_control_flow(input logic [31:0] word);
        return word[6:0] == frontend_pkg::opcode_branch
            || word[6:0] == frontend_pkg::opcode_jal
            || word[6:0] == frontend_pkg::opcode_jalr;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
            err_count++;
        end
    endtask

    always @(negedge clk) begin
        int n;
        logic [frontend_pkg::fetch_width-1:0] exp_en;
        if (rst) begin
            q_inst.delete();
            q_fsq.delete();
            q_off.delete();
            pend_valid = 1'b0;
            err_count = 0;
            in_count = 0;
            out_count = 0;
            model_size = 0;
            full_cycles = 0;
        end else begin
            n = (q_inst.size() > frontend_pkg::fetch_width) ? frontend_pkg::fetch_width
                                                             : q_inst.size();
            for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
                exp_en[i] = (i < n);
            end
            compare("out_en", out_en, exp_en);
            for (int i = 0; i < n; i++) begin
                compare($sformatf("out_inst[%0d]", i), out_inst[i], q_inst[i]);
                compare($sformatf("out_fsq_idx[%0d]", i), out_fsq_idx[i], q_fsq[i]);
                compare($sformatf("out_offset[%0d]", i), out_offset[i], q_off[i]);
                compare($sformatf("out_is_cf[%0d]", i), out_is_cf[i],
                        is_control_flow(q_inst[i]));
            end
            // Fetch is held off while one more packet could still be in flight.
            compare("fetch_ready", fetch_ready,
                    q_inst.size() <= frontend_pkg::ibuf_size - 2 * frontend_pkg::fetch_width);
            compare("full", full, q_inst.size() == frontend_pkg::ibuf_size);
            if (full) begin
                full_cycles++;
            end
            if (redirect) begin
                q_inst.delete();
                q_fsq.delete();
                q_off.delete();
                pend_valid = 1'b0;
            end else begin
                if (!stall) begin
                    for (int i = 0; i < n; i++) begin
                        void'(q_inst.pop_front());
                        void'(q_fsq.pop_front());
                        void'(q_off.pop_front());
                    end
                    // Lanes that the DUT hands to decode at this edge.
                    out_count += $countones(out_en);
                end
                if (pend_valid) begin
                    for (int s = pend_off; s < frontend_pkg::fetch_width; s++) begin
                        q_inst.push_back(pend_inst[s]);
                        q_fsq.push_back(pend_fsq);
                        q_off.push_back(frontend_pkg::offset_w'(s));
                    end
                end
                pend_valid = fetch_valid && fetch_ready;
                pend_off = fetch_offset;
                pend_inst = fetch_inst;
                pend_fsq = fetch_fsq_idx;
                if (pend_valid) begin
                    in_count += frontend_pkg::fetch_width - int'(pend_off);
                end
            end
            model_size = q_inst.size();
        end
    end

endmodule

//--- src/frontend_ibuf.sv
`timescale 1ns/1ps

module frontend_ibuf (
    input  logic clk,
    input  logic rst,
    input  logic fetch_valid,
    input  logic [frontend_pkg::offset_w-1:0] fetch_offset,
    input  logic [frontend_pkg::fetch_width-1:0][31:0] fetch_inst,
    input  logic [frontend_pkg::fsq_idx_w-1:0] fetch_fsq_idx,
    input  logic stall,
    input  logic redirect,
    output logic fetch_ready,
    output logic [frontend_pkg::fetch_width-1:0] out_en,
    output logic [frontend_pkg::fetch_width-1:0][31:0] out_inst,
    output logic [frontend_pkg::fetch_width-1:0][frontend_pkg::fsq_idx_w-1:0] out_fsq_idx,
    output logic [frontend_pkg::fetch_width-1:0][frontend_pkg::offset_w-1:0] out_offset,
    output logic [frontend_pkg::fetch_width-1:0] out_is_cf,
    output logic full
);

    logic no_room;
    frontend_pkg::ibuf_entry_t [frontend_pkg::fetch_width-1:0] out_entry;

    predecode_ibuf_if pkt_if ();

    fetch_packer packer_inst (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .fetch_offset  (fetch_offset),
        .fetch_inst    (fetch_inst),
        .fetch_fsq_idx (fetch_fsq_idx),
        .redirect      (redirect),
        .no_room       (no_room),
        .fetch_ready   (fetch_ready),
        .pkt           (pkt_if.packer)
    );

    inst_buffer buffer_inst (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .redirect  (redirect),
        .pkt       (pkt_if.buffer),
        .no_room   (no_room),
        .full      (full),
        .out_en    (out_en),
        .out_entry (out_entry)
    );

    // Split each entry onto the decode side ports.
    for (genvar i = 0; i < frontend_pkg::fetch_width; i++) begin : g_out
        assign out_inst[i]    = out_entry[i].inst;
        assign out_fsq_idx[i] = out_entry[i].fsq_idx;
        assign out_offset[i]  = out_entry[i].offset;
        assign out_is_cf[i]   = out_entry[i].is_cf;
    end

endmodule

//--- src/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic redirect,
    predecode_ibuf_if.buffer pkt,
    output logic no_room,
    output logic full,
    output logic [frontend_pkg::fetch_width-1:0] out_en,
    output frontend_pkg::ibuf_entry_t [frontend_pkg::fetch_width-1:0] out_entry
);

    logic [frontend_pkg::ibuf_cnt_w-1:0] inst_num;
    logic [frontend_pkg::ibuf_ptr_w-1:0] head;
    logic [frontend_pkg::ibuf_ptr_w-1:0] tail;
    logic [frontend_pkg::bank_idx_w-1:0] head_lo;
    logic [frontend_pkg::bank_idx_w-1:0] tail_lo;

    logic [frontend_pkg::fetch_cnt_w-1:0] out_num;
    logic [frontend_pkg::fetch_cnt_w-1:0] deq_num;

    logic [2*frontend_pkg::ibuf_bank_num-1:0] we_shift;
    logic [2*frontend_pkg::ibuf_bank_num-1:0] re_shift;
    logic [frontend_pkg::ibuf_bank_num-1:0] bank_we;
    logic [frontend_pkg::ibuf_bank_num-1:0] bank_re;

    logic [frontend_pkg::ibuf_bank_num-1:0][frontend_pkg::bank_addr_w-1:0] windex;
    logic [frontend_pkg::ibuf_bank_num-1:0][frontend_pkg::bank_addr_w-1:0] rindex;
    frontend_pkg::ibuf_entry_t [frontend_pkg::ibuf_bank_num-1:0] wdata;
    frontend_pkg::ibuf_entry_t [frontend_pkg::ibuf_bank_num-1:0] rdata;

    assign head_lo = head[frontend_pkg::bank_idx_w-1:0];
    assign tail_lo = tail[frontend_pkg::bank_idx_w-1:0];

    // Up to four entries are visible, stalled or not.
    assign out_num = (inst_num > frontend_pkg::ibuf_cnt_w'(frontend_pkg::fetch_width))
                   ? frontend_pkg::fetch_cnt_w'(frontend_pkg::fetch_width)
                   : frontend_pkg::fetch_cnt_w'(inst_num);
    assign deq_num = stall ? '0 : out_num;
    assign out_en  = ~({frontend_pkg::fetch_width{1'b1}} << out_num);

    // Rotate lane masks onto banks, folding the upper half back around.
    assign we_shift = {{frontend_pkg::ibuf_bank_num{1'b0}}, pkt.en} << tail_lo;
    assign bank_we  = we_shift[frontend_pkg::ibuf_bank_num-1:0]
                    | we_shift[2*frontend_pkg::ibuf_bank_num-1:frontend_pkg::ibuf_bank_num];
    assign re_shift = {{frontend_pkg::ibuf_bank_num{1'b0}}, out_en} << head_lo;
    assign bank_re  = re_shift[frontend_pkg::ibuf_bank_num-1:0]
                    | re_shift[2*frontend_pkg::ibuf_bank_num-1:frontend_pkg::ibuf_bank_num];

    assign no_room = inst_num > frontend_pkg::ibuf_cnt_w'(frontend_pkg::ibuf_room_limit);
    assign full    = inst_num == frontend_pkg::ibuf_cnt_w'(frontend_pkg::ibuf_size);

    for (genvar j = 0; j < frontend_pkg::ibuf_bank_num; j++) begin : g_bank
        logic [frontend_pkg::bank_idx_w-1:0] lane_sel;

        // Bank j takes the lane that lands on it after rotation by tail.
        assign lane_sel = frontend_pkg::bank_idx_w'(j) - tail_lo;
        assign wdata[j] = pkt.entry[lane_sel];

        inst_buffer_bank bank_inst (
            .clk   (clk),
            .rst   (rst),
            .we    (bank_we[j]),
            .din   (wdata[j]),
            .waddr (windex[j]),
            .raddr (rindex[j]),
            .dout  (rdata[j])
        );
    end

    for (genvar i = 0; i < frontend_pkg::fetch_width; i++) begin : g_read
        logic [frontend_pkg::bank_idx_w-1:0] bank_sel;

        assign bank_sel     = head_lo + frontend_pkg::bank_idx_w'(i);
        assign out_entry[i] = rdata[bank_sel];
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            inst_num <= '0;
            head     <= '0;
            tail     <= '0;
            windex   <= '0;
            rindex   <= '0;
        end else begin
            inst_num <= inst_num + frontend_pkg::ibuf_cnt_w'(pkt.num)
                        - frontend_pkg::ibuf_cnt_w'(deq_num);
            if (!stall) begin
                head <= head + frontend_pkg::ibuf_ptr_w'(deq_num);
                for (int j = 0; j < frontend_pkg::ibuf_bank_num; j++) begin
                    rindex[j] <= rindex[j] + frontend_pkg::bank_addr_w'(bank_re[j]);
                end
            end
            if (pkt.en[0]) begin
                tail <= tail + frontend_pkg::ibuf_ptr_w'(pkt.num);
                for (int j = 0; j < frontend_pkg::ibuf_bank_num; j++) begin
                    windex[j] <= windex[j] + frontend_pkg::bank_addr_w'(bank_we[j]);
                end
            end
        end
    end

endmodule

//--- src/fetch_packer.sv
`timescale 1ns/1ps

module fetch_packer (
    input  logic clk,
    input  logic rst,
    input  logic fetch_valid,
    input  logic [frontend_pkg::offset_w-1:0] fetch_offset,
    input  logic [frontend_pkg::fetch_width-1:0][31:0] fetch_inst,
    input  logic [frontend_pkg::fsq_idx_w-1:0] fetch_fsq_idx,
    input  logic redirect,
    input  logic no_room,
    output logic fetch_ready,
    predecode_ibuf_if.packer pkt
);

    logic accept;
    logic [frontend_pkg::fetch_width-1:0][frontend_pkg::offset_w-1:0] lane_slot;
    frontend_pkg::inst_word_u [frontend_pkg::fetch_width-1:0] lane_word;
    frontend_pkg::ibuf_entry_t [frontend_pkg::fetch_width-1:0] lane_entry;

    logic [frontend_pkg::fetch_width-1:0] en_q;
    logic [frontend_pkg::fetch_cnt_w-1:0] num_q;
    frontend_pkg::ibuf_entry_t [frontend_pkg::fetch_width-1:0] entry_q;

    assign fetch_ready = ~no_room;

    // A block offered during redirect is dropped.
    assign accept = fetch_valid & fetch_ready & ~redirect;

    // Lane k takes slot offset+k; lanes past the last slot are masked by en.
    always_comb begin
        for (int k = 0; k < frontend_pkg::fetch_width; k++) begin
            lane_slot[k] = frontend_pkg::offset_w'(fetch_offset + k);
            lane_word[k].raw = fetch_inst[lane_slot[k]];
            lane_entry[k].fsq_idx = fetch_fsq_idx;
            lane_entry[k].offset = lane_slot[k];
            lane_entry[k].is_cf = lane_word[k].r.opcode inside {
                frontend_pkg::opcode_branch,
                frontend_pkg::opcode_jal,
                frontend_pkg::opcode_jalr
            };
            lane_entry[k].inst = lane_word[k].raw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q  <= '0;
            num_q <= '0;
        end else if (accept) begin
            en_q  <= {frontend_pkg::fetch_width{1'b1}} >> fetch_offset;
            num_q <= frontend_pkg::fetch_cnt_w'(frontend_pkg::fetch_width)
                     - frontend_pkg::fetch_cnt_w'(fetch_offset);
        end else begin
            en_q  <= '0;
            num_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            entry_q <= lane_entry;
        end
    end

    assign pkt.en    = en_q;
    assign pkt.num   = num_q;
    assign pkt.entry = entry_q;

endmodule

//--- src/inst_buffer_bank.sv
`timescale 1ns/1ps

module inst_buffer_bank (
    input  logic clk,
    input  logic rst,
    input  logic we,
    input  frontend_pkg::ibuf_entry_t din,
    input  logic [frontend_pkg::bank_addr_w-1:0] waddr,
    input  logic [frontend_pkg::bank_addr_w-1:0] raddr,
    output frontend_pkg::ibuf_entry_t dout
);

    frontend_pkg::ibuf_entry_t mem [frontend_pkg::ibuf_bank_size];

    assign dout = mem[raddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < frontend_pkg::ibuf_bank_size; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= din;
        end
    end

endmodule

//--- src/predecode_ibuf_if.sv
`timescale 1ns/1ps

interface predecode_ibuf_if;

    // Contiguous lane mask, starting at lane 0.
    logic [frontend_pkg::fetch_width-1:0] en;
    logic [frontend_pkg::fetch_cnt_w-1:0] num;
    frontend_pkg::ibuf_entry_t [frontend_pkg::fetch_width-1:0] entry;

    modport packer (
        output en,
        output num,
        output entry
    );

    modport buffer (
        input en,
        input num,
        input entry
    );

endinterface

//--- src/frontend_pkg.sv
package frontend_pkg;

    localparam int fetch_width    = 4;
    localparam int ibuf_bank_num  = 4;
    localparam int ibuf_bank_size = 8;
    localparam int ibuf_size      = 32;
    localparam int fsq_idx_w      = 4;

    localparam int offset_w    = $clog2(fetch_width);
    localparam int fetch_cnt_w = $clog2(fetch_width) + 1;
    localparam int bank_idx_w  = $clog2(ibuf_bank_num);
    localparam int bank_addr_w = $clog2(ibuf_bank_size);
    localparam int ibuf_ptr_w  = $clog2(ibuf_size);
    localparam int ibuf_cnt_w  = ibuf_ptr_w + 1;

    // Keeps room for one packet already in flight.
    localparam int ibuf_room_limit = ibuf_size - 2 * fetch_width;

    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_rtype_t;

    typedef union packed {
        logic [31:0] raw;
        inst_rtype_t r;
    } inst_word_u;

    typedef struct packed {
        logic [fsq_idx_w-1:0] fsq_idx;
        logic [offset_w-1:0]  offset;
        logic                 is_cf;
        logic [31:0]          inst;
    } ibuf_entry_t;

endpackage
